//--- hdl/queue_pkg.sv
`default_nettype none

// Queue configuration for the execution-unit subsystem
package queue_pkg;

    // Storage style of a buffer_fifo
    // LUTRAM uses read/write pointers into a small RAM
    // NON_MUXED_INPUT writes at index zero and muxes the read side
    // NON_MUXED_OUTPUT muxes the write side and reads a fixed register
    typedef enum logic [1:0] {
        LUTRAM_FIFO,
        NON_MUXED_INPUT_FIFO,
        NON_MUXED_OUTPUT_FIFO
    } fifo_type_t;

    // Issue queue, between the issue port and the ALU
    localparam int ISSUE_DEPTH = 4;
    localparam fifo_type_t ISSUE_FIFO_TYPE = NON_MUXED_INPUT_FIFO;

    // Result queue, between the ALU and the result port
    localparam int RESULT_DEPTH = 4;
    localparam fifo_type_t RESULT_FIFO_TYPE = LUTRAM_FIFO;

endpackage

`default_nettype wire

//--- hdl/alu_pkg.sv
`default_nettype none

// ALU operations and the packets that move through the subsystem
package alu_pkg;

    // Operand width
    localparam int XLEN = 32;
    // Instruction id width
    localparam int ID_W = 4;

    // Operation codes
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT
    } alu_op_t;

    // One issued operation, 71 bits
    typedef struct packed {
        logic [ID_W-1:0] id;
        alu_op_t         op;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
    } issue_packet_t;

    // One completed operation, 36 bits
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [XLEN-1:0] rd;
    } result_packet_t;

endpackage

`default_nettype wire

//--- hdl/occupancy_tracker.sv
`timescale 1ns/1ps
`default_nettype none

// One-hot fill level of a small queue
// Bit k of the register is set when the queue holds k entries
module occupancy_tracker #(
    parameter int DEPTH = 4
) (
    input  wire  clk,
    input  wire  rst,
    input  logic push,
    input  logic pop,
    output logic valid,
    output logic empty,
    output logic almost_empty,
    output logic full,
    output logic almost_full
);

    // One bit per fill level, 0 to DEPTH
    logic [DEPTH:0] level;

    ////////////////////////////////////////////////////////////////////////////
    // Level register

    always_ff @(posedge clk) begin
        if (rst) begin
            // Starts empty
            level <= (DEPTH + 1)'(1);
        end else if (push && !pop) begin
            // One more entry
            level <= {level[DEPTH-1:0], 1'b0};
        end else if (pop && !push) begin
            // One less entry
            level <= {1'b0, level[DEPTH:1]};
        end
        // Push with pop leaves the level alone
    end

    ////////////////////////////////////////////////////////////////////////////
    // Status, a single bit or one OR each

    assign empty        = level[0];
    assign valid        = |level[DEPTH:1];
    assign almost_empty = level[1];
    assign full         = level[DEPTH];
    assign almost_full  = level[DEPTH-1];

    // Exactly one fill level at any time
    level_one_hot_a: assert property (@(posedge clk) disable iff (rst) $onehot(level));

endmodule

`default_nettype wire

//--- hdl/buffer_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// Small FIFO for shallow queues
// Push and pop are raw strobes
// Overflow and underflow are guarded by the user
// A push while full is legal only together with a pop
module buffer_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 4,
    parameter queue_pkg::fifo_type_t FIFO_TYPE = queue_pkg::NON_MUXED_INPUT_FIFO
) (
    input  wire      clk,
    input  wire      rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     valid,
    output logic     empty,
    output logic     full,
    output logic     almost_full,
    output logic     almost_empty
);

    // Entry index width
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    generate
    if (DEPTH == 1) begin : gen_single
        ////////////////////////////////////////////////////////////////////////////
        // One register where push wins over pop
        logic held;

        always_ff @(posedge clk) begin
            if (rst) begin
                held <= 1'b0;
            end else if (push) begin
                held <= 1'b1;
            end else if (pop) begin
                held <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                data_out <= data_in;
            end
        end

        assign valid        = held;
        assign empty        = ~held;
        assign full         = held;
        // One entry away from full means empty
        assign almost_full  = ~held;
        assign almost_empty = held;
    end else if (FIFO_TYPE == queue_pkg::LUTRAM_FIFO) begin : gen_lutram
        ////////////////////////////////////////////////////////////////////////////
        // RAM with wrapping read and write pointers
        payload_t         ram [DEPTH];
        logic [IDX_W-1:0] rd_ptr;
        logic [IDX_W-1:0] wr_ptr;

        // Status comes from the one-hot level rather than the pointers
        occupancy_tracker #(
            .DEPTH(DEPTH)
        ) occupancy_i (
            .clk         (clk),
            .rst         (rst),
            .push        (push),
            .pop         (pop),
            .valid       (valid),
            .empty       (empty),
            .almost_empty(almost_empty),
            .full        (full),
            .almost_full (almost_full)
        );

        always_ff @(posedge clk) begin
            if (rst) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == IDX_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == IDX_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                ram[wr_ptr] <= data_in;
            end
        end

        // Asynchronous read of the head
        assign data_out = ram[rd_ptr];
    end else if (FIFO_TYPE == queue_pkg::NON_MUXED_INPUT_FIFO) begin : gen_srl
        ////////////////////////////////////////////////////////////////////////////
        // Shift register written at index zero with the head picked by a mux
        // Index resets to all ones below the top bit
        // The first push rolls it to {1, 0..0} so the top bit doubles as valid
        logic [IDX_W:0]   srl_index;
        logic [IDX_W-1:0] read_pos;
        logic             at_full;
        logic             at_full_minus_one;
        logic             at_one;
        logic             full_r;
        payload_t         shift_reg [DEPTH];

        always_ff @(posedge clk) begin
            if (rst) begin
                srl_index <= {1'b0, {IDX_W{1'b1}}};
            end else begin
                srl_index <= srl_index + (IDX_W + 1)'(push) - (IDX_W + 1)'(pop);
            end
        end

        // Head sits at fill level minus one
        assign read_pos          = srl_index[IDX_W-1:0];
        assign valid             = srl_index[IDX_W];
        assign empty             = ~valid;
        assign at_full           = valid && (read_pos == IDX_W'(DEPTH - 1));
        assign at_full_minus_one = valid && (read_pos == IDX_W'(DEPTH - 2));
        assign at_one            = valid && (read_pos == '0);

        // Full already includes this cycle's push and pop
        // Stays full on a push with pop, fills on a lone push one below full
        always_ff @(posedge clk) begin
            if (rst) begin
                full_r <= 1'b0;
            end else begin
                full_r <= (at_full & (push | ~pop)) | (at_full_minus_one & push & ~pop);
            end
        end

        assign full         = full_r;
        assign almost_full  = at_full_minus_one;
        assign almost_empty = at_one;

        // Every push moves all entries up by one
        always_ff @(posedge clk) begin
            if (push) begin
                shift_reg[0] <= data_in;
                for (int i = 1; i < DEPTH; i++) begin
                    shift_reg[i] <= shift_reg[i-1];
                end
            end
        end

        assign data_out = shift_reg[read_pos];
    end else begin : gen_non_muxed_out
        ////////////////////////////////////////////////////////////////////////////
        // Write slot chosen per entry
        // Entries drain toward slot zero
        localparam int CNT_W = $clog2(DEPTH + 1);

        logic [CNT_W-1:0] count;
        payload_t         shift_reg [DEPTH];
        // Extra top slot catches a push with pop while full
        payload_t         shift_next [DEPTH+1];

        always_ff @(posedge clk) begin
            if (rst) begin
                count <= '0;
            end else begin
                count <= count + CNT_W'(push) - CNT_W'(pop);
            end
        end

        // New data lands at the first free slot
        always_comb begin
            for (int i = 0; i < DEPTH; i++) begin
                if (push && (count == CNT_W'(i))) begin
                    shift_next[i] = data_in;
                end else begin
                    shift_next[i] = shift_reg[i];
                end
            end
            shift_next[DEPTH] = data_in;
        end

        // Pop moves everything down one slot
        always_ff @(posedge clk) begin
            for (int i = 0; i < DEPTH; i++) begin
                shift_reg[i] <= pop ? shift_next[i+1] : shift_next[i];
            end
        end

        assign data_out     = shift_reg[0];
        assign valid        = (count != '0);
        assign empty        = (count == '0);
        assign full         = (count == CNT_W'(DEPTH));
        assign almost_full  = (count == CNT_W'(DEPTH - 1));
        assign almost_empty = (count == CNT_W'(1));
    end
    endgenerate

    ////////////////////////////////////////////////////////////////////////////
    // Usage contract

    // A push on a full queue needs a pop in the same cycle
    no_overflow_a: assert property (@(posedge clk) disable iff (rst) (push && full) |-> pop);

    // No pop from an empty queue
    no_underflow_a: assert property (@(posedge clk) disable iff (rst) pop |-> valid);

endmodule

`default_nettype wire

//--- hdl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

// Single-cycle ALU between the issue queue and the result queue
// Combinational only, result formed in the cycle of the pop
module alu_unit (
    input  alu_pkg::issue_packet_t  issue_head,
    input  logic                    issue_head_valid,
    input  logic                    result_full,
    output logic                    advance,
    output alu_pkg::result_packet_t result_out
);

    logic [alu_pkg::XLEN-1:0] rs1;
    logic [alu_pkg::XLEN-1:0] rs2;
    // Shift amount from the low 5 bits of rs2
    logic [4:0]               shamt;
    logic                     less_than;
    logic [alu_pkg::XLEN-1:0] rd;

    assign rs1   = issue_head.rs1;
    assign rs2   = issue_head.rs2;
    assign shamt = rs2[4:0];

    // Signed compare for SLT
    assign less_than = $signed(rs1) < $signed(rs2);

    ////////////////////////////////////////////////////////////////////////////
    // Operation decode

    always_comb begin
        case (issue_head.op)
            alu_pkg::ADD: rd = rs1 + rs2;
            alu_pkg::SUB: rd = rs1 - rs2;
            alu_pkg::AND: rd = rs1 & rs2;
            alu_pkg::OR:  rd = rs1 | rs2;
            alu_pkg::XOR: rd = rs1 ^ rs2;
            alu_pkg::SLL: rd = rs1 << shamt;
            // Logical right shift with zero fill
            alu_pkg::SRL: rd = rs1 >> shamt;
            alu_pkg::SLT: rd = alu_pkg::XLEN'(less_than);
            default:      rd = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result and handshake

    // Id travels with the result to keep issue order visible
    assign result_out.id = issue_head.id;
    assign result_out.rd = rd;

    // Pops the issue head and pushes the result queue in one strobe
    assign advance = issue_head_valid & ~result_full;

endmodule

`default_nettype wire

//--- hdl/alu_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

// Execution-unit subsystem
// Issue port -> issue queue -> ALU -> result queue -> result port, in order
module alu_subsystem (
    input  wire                     clk,
    input  wire                     rst,
    input  logic                    issue_valid,
    output logic                    issue_ready,
    input  alu_pkg::issue_packet_t  issue,
    output logic                    result_valid,
    input  logic                    result_ready,
    output alu_pkg::result_packet_t result
);

    // Issue side
    logic                    issue_push;
    logic                    issue_full;
    alu_pkg::issue_packet_t  issue_head;
    logic                    issue_head_valid;

    // ALU stage, one strobe pops issue and pushes result
    logic                    advance;
    alu_pkg::result_packet_t alu_result;

    // Result side
    logic                    result_full;
    logic                    result_pop;

    ////////////////////////////////////////////////////////////////////////////
    // Issue queue

    assign issue_ready = ~issue_full;
    assign issue_push  = issue_valid & issue_ready;

    buffer_fifo #(
        .payload_t(alu_pkg::issue_packet_t),
        .DEPTH    (queue_pkg::ISSUE_DEPTH),
        .FIFO_TYPE(queue_pkg::ISSUE_FIFO_TYPE)
    ) issue_fifo_i (
        .clk         (clk),
        .rst         (rst),
        .push        (issue_push),
        .pop         (advance),
        .data_in     (issue),
        .data_out    (issue_head),
        .valid       (issue_head_valid),
        .empty       (),
        .full        (issue_full),
        .almost_full (),
        .almost_empty()
    );

    ////////////////////////////////////////////////////////////////////////////
    // ALU

    alu_unit alu_unit_i (
        .issue_head      (issue_head),
        .issue_head_valid(issue_head_valid),
        .result_full     (result_full),
        .advance         (advance),
        .result_out      (alu_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Result queue

    assign result_pop = result_valid & result_ready;

    buffer_fifo #(
        .payload_t(alu_pkg::result_packet_t),
        .DEPTH    (queue_pkg::RESULT_DEPTH),
        .FIFO_TYPE(queue_pkg::RESULT_FIFO_TYPE)
    ) result_fifo_i (
        .clk         (clk),
        .rst         (rst),
        .push        (advance),
        .pop         (result_pop),
        .data_in     (alu_result),
        .data_out    (result),
        .valid       (result_valid),
        .empty       (),
        .full        (result_full),
        .almost_full (),
        .almost_empty()
    );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock and a reset held over the first edges
module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    // Clock starts low, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Reset covers RESET_CYCLES rising edges
    // Released just after an edge, like every other DUT input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/alu_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the execution-unit subsystem
module alu_subsystem_tb;

    localparam int TOTAL_OPS      = 200;
    localparam int BURST_OPS      = 12;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 12;
    localparam int MAX_IN_FLIGHT  = queue_pkg::ISSUE_DEPTH + queue_pkg::RESULT_DEPTH;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                    clk;
    logic                    rst;
    logic                    issue_valid;
    logic                    issue_ready;
    alu_pkg::issue_packet_t  issue;
    logic                    result_valid;
    logic                    result_ready;
    alu_pkg::result_packet_t result;

    // Expected results in issue order
    alu_pkg::result_packet_t expected_mem [256];
    alu_pkg::result_packet_t expected_head;
    int                      exp_wr;
    int                      exp_rd;
    int                      in_flight;

    // Stimulus state
    logic [31:0]             lfsr_state;
    int                      ready_low_cycles;
    logic                    ready_random;

    // Monitor state
    int                      cycle_count = 0;
    logic                    rst_d = 1'b0;
    logic                    fire_empty_d1;
    logic                    fire_empty_d2;
    logic                    hold_pending;
    alu_pkg::result_packet_t held_result;

    clock_gen #(
        .PERIOD_NS   (10),
        .RESET_CYCLES(2)
    ) clock_gen_i (
        .clk(clk),
        .rst(rst)
    );

    alu_subsystem alu_subsystem_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result      (result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] expected);
        fail_run($sformatf("FAIL %s got %0h expected %0h", name, got, expected));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model

    // Galois form, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // ALU rule, operands as 32-bit words
    function automatic logic [31:0] reference_rd(input alu_pkg::alu_op_t op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (op)
            alu_pkg::ADD: r = a + b;
            // Two's complement negate and add
            alu_pkg::SUB: r = a + ~b + 32'd1;
            alu_pkg::AND: r = a & b;
            alu_pkg::OR:  r = a | b;
            alu_pkg::XOR: r = a ^ b;
            alu_pkg::SLL: r = a << b[4:0];
            alu_pkg::SRL: r = a >> b[4:0];
            // Mixed signs, the negative one is smaller
            alu_pkg::SLT: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            default:      r = '0;
        endcase
        return r;
    endfunction

    function automatic alu_pkg::issue_packet_t make_op(input int index);
        alu_pkg::issue_packet_t pkt;
        logic [2:0]             op_bits;
        op_bits = 3'(take_bits(3));
        pkt.id  = alu_pkg::ID_W'(index);
        pkt.op  = alu_pkg::alu_op_t'(op_bits);
        pkt.rs1 = take_bits(32);
        pkt.rs2 = take_bits(32);
        // Equal operands now and then, SUB to zero and SLT ties
        if (take_bits(3) == 32'd0) begin
            pkt.rs2 = pkt.rs1;
        end
        return pkt;
    endfunction

    // Appended on every accepted issue, consumed on every result taken
    always_ff @(posedge clk) begin
        if (rst) begin
            exp_wr <= 0;
            exp_rd <= 0;
        end else begin
            if (issue_valid && issue_ready) begin
                expected_mem[exp_wr[7:0]] <= '{id: issue.id,
                                               rd: reference_rd(issue.op, issue.rs1, issue.rs2)};
                exp_wr <= exp_wr + 1;
            end
            if (result_valid && result_ready) begin
                exp_rd <= exp_rd + 1;
            end
        end
    end

    assign expected_head = expected_mem[exp_rd[7:0]];
    assign in_flight     = exp_wr - exp_rd;

    ////////////////////////////////////////////////////////////////////////////
    // Monitor registers and timeout

    always_ff @(posedge clk) begin
        if (rst) begin
            fire_empty_d1 <= 1'b0;
            fire_empty_d2 <= 1'b0;
            hold_pending  <= 1'b0;
        end else begin
            // Issue taken while nothing is outstanding
            fire_empty_d1 <= issue_valid && issue_ready && (in_flight == 0);
            fire_empty_d2 <= fire_empty_d1;
            hold_pending  <= result_valid && !result_ready;
        end
        held_result <= result;
        rst_d       <= rst;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, %0d of %0d results seen",
                               cycle_count, exp_rd, TOTAL_OPS));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    rd_match_a: assert property (@(posedge clk) disable iff (rst)
        (result_valid && in_flight != 0) |-> (result.rd == expected_head.rd))
        else report_value("result.rd", $sampled(result.rd), $sampled(expected_head.rd));

    // Issue order seen through the id
    id_order_a: assert property (@(posedge clk) disable iff (rst)
        (result_valid && in_flight != 0) |-> (result.id == expected_head.id))
        else report_value("result.id", $sampled(result.id), $sampled(expected_head.id));

    no_extra_result_a: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> (in_flight != 0))
        else fail_run("Result offered with no operation outstanding");

    // Stalled result must not move
    result_stable_a: assert property (@(posedge clk) disable iff (rst)
        hold_pending |-> (result_valid && result == held_result))
        else report_value("result", $sampled(result), $sampled(held_result));

    reset_result_valid_a: assert property (@(posedge clk)
        rst_d |-> !result_valid)
        else report_value("result_valid", $sampled(result_valid), 64'd0);

    reset_issue_ready_a: assert property (@(posedge clk)
        rst_d |-> issue_ready)
        else report_value("issue_ready", $sampled(issue_ready), 64'd1);

    // Both queues full
    backlog_stall_a: assert property (@(posedge clk) disable iff (rst)
        (in_flight == MAX_IN_FLIGHT) |-> !issue_ready)
        else report_value("issue_ready", $sampled(issue_ready), 64'd0);

    // One below full, ready may trail a drain by a cycle
    backlog_room_a: assert property (@(posedge clk) disable iff (rst)
        (in_flight <= MAX_IN_FLIGHT - 2) |-> issue_ready)
        else report_value("issue_ready", $sampled(issue_ready), 64'd1);

    // Two edges from issue to result_valid
    latency_low_a: assert property (@(posedge clk) disable iff (rst)
        fire_empty_d1 |-> !result_valid)
        else report_value("result_valid", $sampled(result_valid), 64'd0);

    latency_high_a: assert property (@(posedge clk) disable iff (rst)
        fire_empty_d2 |-> result_valid)
        else report_value("result_valid", $sampled(result_valid), 64'd1);

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // Inputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (ready_low_cycles > 0) begin
            result_ready = 1'b0;
            ready_low_cycles = ready_low_cycles - 1;
        end else if (ready_random) begin
            // High three times in four
            result_ready = (take_bits(2) != 32'd0);
        end else begin
            result_ready = 1'b1;
        end
    endtask

    task automatic send_op(input alu_pkg::issue_packet_t pkt);
        issue_valid = 1'b1;
        issue = pkt;
        while (!issue_ready) begin
            next_cycle();
        end
        next_cycle();
        issue_valid = 1'b0;
    endtask

    initial begin
        int sent;
        int gap;
        issue_valid = 1'b0;
        issue = '0;
        result_ready = 1'b0;
        lfsr_state = 32'hf1677bda;
        ready_low_cycles = 0;
        ready_random = 1'b0;
        sent = 0;
        @(negedge rst);
        next_cycle();

        // Lone operation into an empty subsystem
        send_op(make_op(sent));
        sent++;
        while (in_flight != 0) begin
            next_cycle();
        end

        // Result port stalled long enough for both queues to fill
        ready_low_cycles = 16;
        for (int i = 0; i < BURST_OPS; i++) begin
            send_op(make_op(sent));
            sent++;
        end
        while (in_flight != 0) begin
            next_cycle();
        end

        // Random issue gaps and random back-pressure
        ready_random = 1'b1;
        while (sent < TOTAL_OPS) begin
            gap = int'(take_bits(2));
            repeat (gap) next_cycle();
            send_op(make_op(sent));
            sent++;
        end
        while (exp_rd != TOTAL_OPS) begin
            next_cycle();
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/queue_pkg.sv
hdl/alu_pkg.sv
hdl/occupancy_tracker.sv
hdl/buffer_fifo.sv
hdl/alu_unit.sv
hdl/alu_subsystem.sv
verification/clock_gen.sv
verification/alu_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := alu_subsystem_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
